//--- source/coreTypes.sv
package coreTypes;

	localparam int DataWidth = 32;

	// major opcodes of the supported RV32I subset
	typedef enum logic [6:0] {
		opReg    = 7'b0110011,
		opImm    = 7'b0010011,
		opLui    = 7'b0110111,
		opLoad   = 7'b0000011,
		opStore  = 7'b0100011,
		opBranch = 7'b1100011,
		opJal    = 7'b1101111,
		opSystem = 7'b1110011
	} opcodeT;

	typedef enum logic [3:0] {
		aluAdd,
		aluSub,
		aluAnd,
		aluOr,
		aluXor,
		aluSlt,
		aluSll,
		aluSrl,
		aluPassB
	} aluOpT;

	typedef struct packed {
		aluOpT aluOp;
		logic  aluSrcImm;
		logic  regWrite;
		logic  memToReg;
		logic  memRead;
		logic  memWrite;
		logic  branch;
		logic  branchOnNotZero;
		logic  jump;
		logic  halt;
	} controlT;

	// address is a word address, not a byte address
	typedef struct packed {
		logic                 write;
		logic [31:0]          address;
		logic [DataWidth-1:0] writeData;
	} memReqT;

endpackage

//--- source/registerFile.sv
`timescale 1ns/1ps

module registerFile import coreTypes::*; (
	input  logic                 clk,
	input  logic [4:0]           rsAddr1,
	input  logic [4:0]           rsAddr2,
	input  logic [4:0]           rdAddr,
	input  logic                 writeEnable,
	input  logic [DataWidth-1:0] writeData,
	output logic [DataWidth-1:0] readData1,
	output logic [DataWidth-1:0] readData2
);

	logic [DataWidth-1:0] regs [32];

	always_ff @(posedge clk) begin
		if (writeEnable && rdAddr != 5'd0) begin
			regs[rdAddr] <= writeData;
		end
	end

	// x0 never holds anything but zero
	assign readData1 = (rsAddr1 == 5'd0) ? '0 : regs[rsAddr1];
	assign readData2 = (rsAddr2 == 5'd0) ? '0 : regs[rsAddr2];

endmodule

//--- source/decoder.sv
`timescale 1ns/1ps

module decoder import coreTypes::*; (
	input  logic [DataWidth-1:0] instruction,
	output controlT              control,
	output logic [DataWidth-1:0] immediate,
	output logic [4:0]           rs1,
	output logic [4:0]           rs2,
	output logic [4:0]           rd
);

	opcodeT     opcode;
	logic [2:0] funct3;
	logic [6:0] funct7;

	function automatic aluOpT aluFromFunct(input logic [2:0] f3, input logic subtract);
		case (f3)
			3'b000:  aluFromFunct = subtract ? aluSub : aluAdd;
			3'b001:  aluFromFunct = aluSll;
			3'b010:  aluFromFunct = aluSlt;
			3'b100:  aluFromFunct = aluXor;
			3'b101:  aluFromFunct = aluSrl;
			3'b110:  aluFromFunct = aluOr;
			3'b111:  aluFromFunct = aluAnd;
			default: aluFromFunct = aluAdd;
		endcase
	endfunction

	assign opcode = opcodeT'(instruction[6:0]);
	assign funct3 = instruction[14:12];
	assign funct7 = instruction[31:25];
	assign rs1    = instruction[19:15];
	assign rs2    = instruction[24:20];
	assign rd     = instruction[11:7];

	always_comb begin
		control       = '0;
		control.aluOp = aluAdd;
		// I format unless the opcode says otherwise
		immediate     = {{20{instruction[31]}}, instruction[31:20]};
		case (opcode)
			opReg: begin
				control.aluOp    = aluFromFunct(funct3, funct7[5]);
				control.regWrite = 1'b1;
			end
			opImm: begin
				control.aluOp     = aluFromFunct(funct3, 1'b0);
				control.aluSrcImm = 1'b1;
				control.regWrite  = 1'b1;
			end
			opLui: begin
				immediate         = {instruction[31:12], 12'b0};
				control.aluOp     = aluPassB;
				control.aluSrcImm = 1'b1;
				control.regWrite  = 1'b1;
			end
			opLoad: begin
				control.aluSrcImm = 1'b1;
				control.regWrite  = 1'b1;
				control.memToReg  = 1'b1;
				control.memRead   = 1'b1;
			end
			opStore: begin
				immediate         = {{20{instruction[31]}}, instruction[31:25], instruction[11:7]};
				control.aluSrcImm = 1'b1;
				control.memWrite  = 1'b1;
			end
			opBranch: begin
				immediate = {{19{instruction[31]}}, instruction[31], instruction[7],
					instruction[30:25], instruction[11:8], 1'b0};
				control.aluOp  = aluSub;
				control.branch = 1'b1;
				// funct3 001 is bne
				control.branchOnNotZero = funct3[0];
			end
			opJal: begin
				immediate = {{11{instruction[31]}}, instruction[31], instruction[19:12],
					instruction[20], instruction[30:21], 1'b0};
				control.jump     = 1'b1;
				control.regWrite = 1'b1;
			end
			// ebreak, and anything unknown, stops the core
			default: control.halt = 1'b1;
		endcase
	end

endmodule

//--- source/alu.sv
`timescale 1ns/1ps

module alu import coreTypes::*; (
	input  logic [DataWidth-1:0] operandA,
	input  logic [DataWidth-1:0] operandB,
	input  aluOpT                operation,
	output logic [DataWidth-1:0] result,
	output logic                 zero
);

	logic lessThan;

	// signed compare for slt and slti
	assign lessThan = $signed(operandA) < $signed(operandB);

	always_comb begin
		case (operation)
			aluAdd:   result = operandA + operandB;
			aluSub:   result = operandA - operandB;
			aluAnd:   result = operandA & operandB;
			aluOr:    result = operandA | operandB;
			aluXor:   result = operandA ^ operandB;
			aluSlt:   result = {{(DataWidth-1){1'b0}}, lessThan};
			aluSll:   result = operandA << operandB[4:0];
			aluSrl:   result = operandA >> operandB[4:0];
			aluPassB: result = operandB;
			default:  result = '0;
		endcase
	end

	assign zero = (result == '0);

endmodule

//--- source/memArbiter.sv
`timescale 1ns/1ps

module memArbiter import coreTypes::*; #(
	parameter int MemWords = 1024
) (
	input  logic                        clk,
	input  logic                        rstN,
	input  memReqT                      hostReq,
	input  memReqT                      dataReq,
	input  memReqT                      fetchReq,
	input  logic                        hostValid,
	input  logic                        dataValid,
	input  logic                        fetchValid,
	output logic                        hostReady,
	output logic                        dataReady,
	output logic                        fetchReady,
	output logic                        hostRespValid,
	output logic                        dataRespValid,
	output logic                        fetchRespValid,
	output logic [DataWidth-1:0]        respData,
	output logic                        memEnable,
	output logic                        memWrite,
	output logic [$clog2(MemWords)-1:0] memAddr,
	output logic [DataWidth-1:0]        memWriteData,
	input  logic [DataWidth-1:0]        memReadData
);

	localparam int AddrBits = $clog2(MemWords);

	memReqT grantedReq;

	// fixed priority: host, then data, then fetch
	assign hostReady  = hostValid;
	assign dataReady  = dataValid && !hostValid;
	assign fetchReady = fetchValid && !hostValid && !dataValid;

	always_comb begin
		if (hostValid) begin
			grantedReq = hostReq;
		end else if (dataValid) begin
			grantedReq = dataReq;
		end else begin
			grantedReq = fetchReq;
		end
	end

	assign memEnable    = hostValid || dataValid || fetchValid;
	assign memWrite     = grantedReq.write;
	// upper address bits are dropped
	assign memAddr      = grantedReq.address[AddrBits-1:0];
	assign memWriteData = grantedReq.writeData;
	assign respData     = memReadData;

	// remember who was granted so the response goes back to them only
	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			hostRespValid  <= 1'b0;
			dataRespValid  <= 1'b0;
			fetchRespValid <= 1'b0;
		end else begin
			hostRespValid  <= hostReady;
			dataRespValid  <= dataReady;
			fetchRespValid <= fetchReady;
		end
	end

	oneGrant: assert property (@(posedge clk) disable iff (!rstN)
		$onehot0({hostReady, dataReady, fetchReady}));

endmodule

//--- source/unifiedMemory.sv
`timescale 1ns/1ps

module unifiedMemory import coreTypes::*; #(
	parameter int MemWords = 1024
) (
	input  logic                        clk,
	input  logic                        enable,
	input  logic                        write,
	input  logic [$clog2(MemWords)-1:0] address,
	input  logic [DataWidth-1:0]        writeData,
	output logic [DataWidth-1:0]        readData
);

	logic [DataWidth-1:0] mem [MemWords];

	// read data is registered, one cycle behind the request
	always_ff @(posedge clk) begin
		if (enable) begin
			if (write) begin
				mem[address] <= writeData;
			end else begin
				readData <= mem[address];
			end
		end
	end

endmodule

//--- source/riscCore.sv
`timescale 1ns/1ps

module riscCore import coreTypes::*; (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 run,
	output logic                 halted,
	output memReqT               fetchReq,
	output logic                 fetchValid,
	input  logic                 fetchReady,
	input  logic                 fetchRespValid,
	output memReqT               dataReq,
	output logic                 dataValid,
	input  logic                 dataReady,
	input  logic                 dataRespValid,
	input  logic [DataWidth-1:0] respData
);

	typedef enum logic [2:0] {
		idle,
		fetch,
		waitFetch,
		execute,
		memAccess,
		waitMem,
		haltedState
	} stateT;

	stateT                state;
	logic [DataWidth-1:0] pc;
	logic [DataWidth-1:0] ir;
	logic [DataWidth-1:0] pcPlus4;
	logic [DataWidth-1:0] pcTarget;
	logic [DataWidth-1:0] immediate;
	logic [DataWidth-1:0] readData1;
	logic [DataWidth-1:0] readData2;
	logic [DataWidth-1:0] operandB;
	logic [DataWidth-1:0] aluResult;
	logic [DataWidth-1:0] writeData;
	logic [4:0]           rs1;
	logic [4:0]           rs2;
	logic [4:0]           rd;
	logic                 zero;
	logic                 takeTarget;
	logic                 regWriteEnable;
	controlT              control;

	decoder decoder_inst (
		.instruction (ir),
		.control     (control),
		.immediate   (immediate),
		.rs1         (rs1),
		.rs2         (rs2),
		.rd          (rd)
	);

	registerFile registerFile_inst (
		.clk         (clk),
		.rsAddr1     (rs1),
		.rsAddr2     (rs2),
		.rdAddr      (rd),
		.writeEnable (regWriteEnable),
		.writeData   (writeData),
		.readData1   (readData1),
		.readData2   (readData2)
	);

	assign operandB = control.aluSrcImm ? immediate : readData2;

	alu alu_inst (
		.operandA  (readData1),
		.operandB  (operandB),
		.operation (control.aluOp),
		.result    (aluResult),
		.zero      (zero)
	);

	assign pcPlus4    = pc + 32'd4;
	assign pcTarget   = pc + immediate;
	// beq wants zero, bne wants nonzero
	assign takeTarget = control.jump || (control.branch && (zero != control.branchOnNotZero));

	// loads write back when the data arrives, everything else in execute
	assign regWriteEnable = (state == execute && control.regWrite && !control.memToReg)
		|| (state == waitMem && dataRespValid && control.memToReg);
	assign writeData = (state == waitMem) ? respData : (control.jump ? pcPlus4 : aluResult);

	// byte addresses become word addresses here
	assign fetchValid = (state == fetch);
	assign fetchReq   = '{write: 1'b0, address: {2'b00, pc[31:2]}, writeData: '0};
	assign dataValid  = (state == memAccess);
	assign dataReq    = '{write: control.memWrite, address: {2'b00, aluResult[31:2]},
		writeData: readData2};
	assign halted     = (state == haltedState);

	always_ff @(posedge clk) begin
		if (state == waitFetch && fetchRespValid) begin
			ir <= respData;
		end
	end

	always_ff @(posedge clk or negedge rstN) begin
		if (!rstN) begin
			state <= idle;
			pc    <= '0;
		end else begin
			case (state)
				idle: begin
					pc <= '0;
					if (run) state <= fetch;
				end
				fetch:     if (fetchReady) state <= waitFetch;
				waitFetch: if (fetchRespValid) state <= execute;
				execute: begin
					if (control.halt) begin
						state <= haltedState;
					end else begin
						pc <= takeTarget ? pcTarget : pcPlus4;
						if (control.memRead || control.memWrite) begin
							state <= memAccess;
						end else begin
							state <= fetch;
						end
					end
				end
				memAccess:   if (dataReady) state <= waitMem;
				waitMem:     if (dataRespValid) state <= fetch;
				haltedState: if (!run) state <= idle;
				default:     state <= idle;
			endcase
		end
	end

	oneRequest: assert property (@(posedge clk) disable iff (!rstN)
		!(fetchValid && dataValid));

	// the arbiter must route each response to the waiting requester
	respRouted: assert property (@(posedge clk) disable iff (!rstN)
		(fetchRespValid |-> state == waitFetch) and (dataRespValid |-> state == waitMem));

endmodule

//--- source/riscTop.sv
`timescale 1ns/1ps

module riscTop import coreTypes::*; #(
	parameter int MemWords = 1024
) (
	input  logic                 clk,
	input  logic                 rstN,
	input  logic                 run,
	output logic                 halted,
	input  memReqT               hostReq,
	input  logic                 hostValid,
	output logic                 hostReady,
	output logic                 hostRespValid,
	output logic [DataWidth-1:0] hostReadData
);

	memReqT                      fetchReq;
	memReqT                      dataReq;
	logic                        fetchValid;
	logic                        fetchReady;
	logic                        fetchRespValid;
	logic                        dataValid;
	logic                        dataReady;
	logic                        dataRespValid;
	logic [DataWidth-1:0]        respData;
	logic                        memEnable;
	logic                        memWrite;
	logic [$clog2(MemWords)-1:0] memAddr;
	logic [DataWidth-1:0]        memWriteData;
	logic [DataWidth-1:0]        memReadData;

	// host sees the shared response bus directly
	assign hostReadData = respData;

	riscCore riscCore_inst (
		.clk            (clk),
		.rstN           (rstN),
		.run            (run),
		.halted         (halted),
		.fetchReq       (fetchReq),
		.fetchValid     (fetchValid),
		.fetchReady     (fetchReady),
		.fetchRespValid (fetchRespValid),
		.dataReq        (dataReq),
		.dataValid      (dataValid),
		.dataReady      (dataReady),
		.dataRespValid  (dataRespValid),
		.respData       (respData)
	);

	memArbiter #(.MemWords(MemWords)) memArbiter_inst (
		.clk            (clk),
		.rstN           (rstN),
		.hostReq        (hostReq),
		.dataReq        (dataReq),
		.fetchReq       (fetchReq),
		.hostValid      (hostValid),
		.dataValid      (dataValid),
		.fetchValid     (fetchValid),
		.hostReady      (hostReady),
		.dataReady      (dataReady),
		.fetchReady     (fetchReady),
		.hostRespValid  (hostRespValid),
		.dataRespValid  (dataRespValid),
		.fetchRespValid (fetchRespValid),
		.respData       (respData),
		.memEnable      (memEnable),
		.memWrite       (memWrite),
		.memAddr        (memAddr),
		.memWriteData   (memWriteData),
		.memReadData    (memReadData)
	);

	unifiedMemory #(.MemWords(MemWords)) unifiedMemory_inst (
		.clk       (clk),
		.enable    (memEnable),
		.write     (memWrite),
		.address   (memAddr),
		.writeData (memWriteData),
		.readData  (memReadData)
	);

endmodule

//--- bench/riscTopTb.sv
`timescale 1ns/1ps

module riscTopTb import coreTypes::*; ();

	localparam int MemWords = 1024;

	typedef struct packed {
		logic [7:0]        cmd;
		logic [31:0]       address;
		logic [31:0]       data;
		logic [8*40-1:0]   name;
	} stimT;

	logic                 clk;
	logic                 rstN;
	logic                 run;
	logic                 halted;
	memReqT               hostReq;
	logic                 hostValid;
	logic                 hostReady;
	logic                 hostRespValid;
	logic [DataWidth-1:0] hostReadData;

	stimT                 steps [$];
	logic [8*40-1:0]      testName = "startup";
	int                   watchdogCycles = 0;

	riscTop #(.MemWords(MemWords)) riscTop_inst (
		.clk           (clk),
		.rstN          (rstN),
		.run           (run),
		.halted        (halted),
		.hostReq       (hostReq),
		.hostValid     (hostValid),
		.hostReady     (hostReady),
		.hostRespValid (hostRespValid),
		.hostReadData  (hostReadData)
	);

	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk;
	end

	task automatic stopWithFailure(input string reason);
		$display("%0s", reason);
		$display("*** FAILED ***");
		$fatal(1, "simulation stopped");
	endtask

	task automatic compareWord(input logic [31:0] expected, input logic [31:0] actual);
		if (actual !== expected) begin
			stopWithFailure($sformatf("** Error [%0s] expected %h, actual %h",
				testName, expected, actual));
		end
	endtask

	// reads the whole stim file into a queue and sizes the time limit
	task automatic loadSteps;
		int              fd;
		int              rc;
		int              lineCount;
		int              runCount;
		logic [7:0]      cmd;
		logic [31:0]     address;
		logic [31:0]     data;
		logic [8*40-1:0] name;
		logic [8*128-1:0] restOfLine;
		stimT            step;
		lineCount = 0;
		runCount  = 0;
		fd = $fopen("bench/riscStim.txt", "r");
		if (fd == 0) begin
			stopWithFailure("could not open bench/riscStim.txt");
		end
		while ($fscanf(fd, "%s", cmd) == 1) begin
			lineCount++;
			step     = '0;
			step.cmd = cmd;
			case (cmd)
				"#": rc = $fgets(restOfLine, fd);
				"W", "R": begin
					rc = $fscanf(fd, "%h %h", address, data);
					if (rc != 2) stopWithFailure("stim line is missing its address or data");
					step.address = address;
					step.data    = data;
				end
				"N": begin
					rc = $fscanf(fd, "%s", name);
					step.name = name;
				end
				"G": runCount++;
				default: stopWithFailure("stim file holds an unknown command");
			endcase
			if (cmd != "#") steps.push_back(step);
		end
		$fclose(fd);
		watchdogCycles = lineCount * 200 + runCount * 5000;
	endtask

	// response must follow one cycle after the host request is accepted
	task automatic hostAccess(input logic isWrite, input logic [31:0] address,
			input logic [31:0] data, output logic [31:0] readData);
		@(posedge clk);
		hostReq.write     <= isWrite;
		hostReq.address   <= address;
		hostReq.writeData <= data;
		hostValid         <= 1'b1;
		@(negedge clk);
		while (!hostReady) @(negedge clk);
		@(posedge clk);
		hostValid <= 1'b0;
		@(negedge clk);
		compareWord(32'd1, {31'd0, hostRespValid});
		readData = hostReadData;
	endtask

	task automatic runProgram;
		@(posedge clk);
		run <= 1'b1;
		@(negedge clk);
		while (!halted) @(negedge clk);
		@(posedge clk);
		run <= 1'b0;
		// core back in idle before the host reads
		@(negedge clk);
		while (halted) @(negedge clk);
	endtask

	initial begin
		wait (watchdogCycles > 0);
		repeat (watchdogCycles) @(posedge clk);
		stopWithFailure("timeout, the run did not finish in the allowed number of cycles");
	end

	initial begin
		stimT        step;
		logic [31:0] readBack;
		rstN      = 1'b0;
		run       = 1'b0;
		hostValid = 1'b0;
		hostReq   = '0;
		loadSteps();
		repeat (5) @(posedge clk);
		rstN <= 1'b1;
		for (int i = 0; i < steps.size(); i++) begin
			step = steps[i];
			case (step.cmd)
				"N": testName = step.name;
				"W": hostAccess(1'b1, step.address, step.data, readBack);
				"R": begin
					hostAccess(1'b0, step.address, 32'd0, readBack);
					compareWord(step.data, readBack);
				end
				"G": runProgram();
				default: stopWithFailure("queued step has an unknown command");
			endcase
		end
		$display("*** PASSED ***");
		$finish;
	end

endmodule

//--- riscTop.f
source/coreTypes.sv
source/registerFile.sv
source/decoder.sv
source/alu.sv
source/memArbiter.sv
source/unifiedMemory.sv
source/riscCore.sv
source/riscTop.sv
bench/riscTopTb.sv

//--- bench/riscStim.txt
# columns: W wordAddress data | R wordAddress expected | G | N testName
# addresses and data are hex, addresses are word addresses
N host_readback
W 3F0 A5A55A5A
W 3FF 01234567
R 3F0 A5A55A5A
R 3FF 01234567
N register_alu
W 00 06400093
W 01 FF900113
W 02 002081B3
W 03 20302023
W 04 402081B3
W 05 20302223
W 06 0020F1B3
W 07 20302423
W 08 0020E1B3
W 09 20302623
W 0A 0020C1B3
W 0B 20302823
W 0C 00112233
W 0D 20402A23
W 0E 004091B3
W 0F 20302C23
W 10 004151B3
W 11 20302E23
W 12 22202023
W 13 03C0F193
W 14 22302223
W 15 F000E193
W 16 22302423
W 17 0FF14193
W 18 22302623
W 19 FFD12193
W 1A 22302823
W 1B 123452B7
W 1C 67828293
W 1D 22502A23
W 1E 00000293
W 1F 00A00313
W 20 006282B3
W 21 FFF30313
W 22 FE031CE3
W 23 22502C23
W 24 00500493
W 25 00000463
W 26 00100493
W 27 00008463
W 28 00248493
W 29 22902E23
W 2A 0080056F
W 2B 00100073
W 2C 24A02023
W 2D 30002583
W 2E 01058593
W 2F 24B02223
W 30 00008013
W 31 24002423
W 32 00100073
W C0 CAFE0000
W 92 DEADBEEF
G
R 80 0000005D
R 81 0000006B
R 82 00000060
R 83 FFFFFFFD
R 84 FFFFFF9D
R 85 00000001
R 86 000000C8
R 87 7FFFFFFC
N immediate_forms
R 88 FFFFFFF9
R 89 00000024
R 8A FFFFFF64
R 8B FFFFFF06
R 8C 00000001
R 8D 12345678
N branches_and_jal
R 8E 00000037
R 8F 00000007
R 90 000000AC
N load_store_x0
R 91 CAFE0010
R 92 00000000
N unknown_opcode_halts
W 00 05A00613
W 01 28C02023
W 02 FFFFFFFF
W 03 28C02223
W A1 11111111
G
R A0 0000005A
R A1 11111111
